// ==== tb.f ====
hdl/emaxi_pkg.sv
hdl/axi_skid_stage.sv
hdl/write_port.sv
hdl/readinfo_fifo.sv
hdl/read_port.sv
hdl/emaxi_top.sv
bench/emaxi_checker.sv
bench/emaxi_tb.sv

// ==== Makefile ====
# Verilator flow for the eLink to AXI bridge

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f tb.f --top-module emaxi_tb

sim:
	verilator --binary --timing --assert -f tb.f --top-module emaxi_tb -o emaxi_sim
	./obj_dir/emaxi_sim | tee sim.log
	grep -qx "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/emaxi_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module emaxi_tb;

   import emaxi_pkg::*;

   localparam int clk_half    = 2;    // 4 ns period
   localparam int n_wr_basic  = 40;
   localparam int n_wr_rand   = 60;
   localparam int n_rd_basic  = 40;
   localparam int n_rd_rand   = 40;
   localparam int n_rd_wait   = 40;
   localparam int pkt_total   = n_wr_basic + n_wr_rand + n_rd_basic + n_rd_rand + n_rd_wait;
   localparam int cycle_bound = 60;   // generous per packet, stalls included

   logic                  m_axi_aclk;
   logic                  m_axi_aresetn;
   logic                  rxwr_access;
   emesh_packet_t         rxwr_packet;
   logic                  rxwr_wait;
   logic                  rxrd_access;
   emesh_packet_t         rxrd_packet;
   logic                  rxrd_wait;
   logic                  txrr_access;
   emesh_packet_t         txrr_packet;
   logic                  txrr_wait;
   logic [addr_w-1:0]     m_axi_awaddr;
   logic [axi_size_w-1:0] m_axi_awsize;
   logic                  m_axi_awvalid;
   logic                  m_axi_awready;
   logic [axi_data_w-1:0] m_axi_wdata;
   logic [axi_strb_w-1:0] m_axi_wstrb;
   logic                  m_axi_wlast;
   logic                  m_axi_wvalid;
   logic                  m_axi_wready;
   logic [addr_w-1:0]     m_axi_araddr;
   logic [axi_size_w-1:0] m_axi_arsize;
   logic                  m_axi_arvalid;
   logic                  m_axi_arready;
   logic [axi_data_w-1:0] m_axi_rdata;
   logic                  m_axi_rvalid;
   logic                  m_axi_rready;

   logic [31:0]   lfsr = 32'habc566a2;
   bit            rand_slave;                  // random readies and rvalid
   bit            rand_wait;                   // random txrr_wait
   emesh_packet_t rd_pkt;                      // read request on the port now
   axi_addr_t     exp_aw [$];
   axi_wdata_t    exp_w [$];
   axi_addr_t     seen_aw [$];                 // slave side, waiting for a partner
   axi_wdata_t    seen_w [$];
   logic [63:0]   rd_q [$];                    // slave read data, in order
   emesh_packet_t exp_rsp [$];
   int            r_cycle_q [$];               // cycle of each r handshake
   logic [63:0]   mem [logic [28:0]];          // 64-bit words by addr[31:3]
   int            cycle;
   int            ar_count;
   int            rsp_count;
   int            wait_rsp;                    // responses seen while txrr_wait high
   int            errors;
   int            checks;

   emaxi_top dut (.*);

   initial
   begin
      m_axi_aclk = 1'b0;
      forever #(clk_half) m_axi_aclk = ~m_axi_aclk;
   end

   // ##############################
   // helpers
   // ##############################
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++)
      begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];   // taps 32 22 2 1
         lfsr = {lfsr[30:0], fb};
         r    = {r[30:0], fb};
      end
      return r;
   endfunction

   function automatic logic [63:0] fill_word(input logic [28:0] idx);
      return {3'b101, idx, ~idx, 3'b011};   // unwritten words, whole index in it
   endfunction

   function automatic logic [63:0] mem_word(input logic [28:0] idx);
      if (mem.exists(idx))
         return mem[idx];
      return fill_word(idx);
   endfunction

   function automatic void merge_write(input axi_addr_t a, input axi_wdata_t w);
      logic [63:0] word;
      word = mem_word(a.addr[31:3]);
      for (int k = 0; k < 8; k++)
         if (w.strb[k])
            word[8*k +: 8] = w.data[8*k +: 8];
      mem[a.addr[31:3]] = word;
   endfunction

   // expected w beat, payload repeated per lane, strobe on the addressed lane
   function automatic axi_wdata_t expect_wbeat(input emesh_packet_t p);
      axi_wdata_t b;
      int         nbytes;
      int         lane;
      nbytes = 1 << int'(p.datamode);
      lane   = int'(p.dstaddr[2:0]) / nbytes;
      if (p.datamode == dm_dword)
      begin
         b.data = {p.srcaddr, p.data};
         b.strb = '1;
      end
      else
         for (int k = 0; k < 8; k++)
         begin
            b.data[8*k +: 8] = p.data[8*(k % nbytes) +: 8];
            b.strb[k]        = (k / nbytes == lane);
         end
      return b;
   endfunction

   function automatic emesh_packet_t expect_rsp(input emesh_packet_t req, input logic [63:0] word);
      emesh_packet_t p;
      int            nbytes;
      int            off;
      nbytes     = 1 << int'(req.datamode);
      off        = (int'(req.dstaddr[2:0]) / nbytes) * nbytes;   // first byte of the lane
      p          = '0;
      p.access   = 1'b1;
      p.write    = 1'b1;
      p.datamode = req.datamode;
      p.ctrlmode = req.ctrlmode;
      p.dstaddr  = req.srcaddr;
      p.srcaddr  = word[63:32];
      if (req.datamode == dm_dword)
         p.data = word[31:0];
      else
         for (int k = 0; k < nbytes; k++)
            p.data[8*k +: 8] = word[8*(off+k) +: 8];
      return p;
   endfunction

   function automatic emesh_packet_t random_packet(input bit is_write);
      emesh_packet_t p;
      logic [31:0]   r;
      logic [2:0]    lo;
      p          = '0;
      p.access   = 1'b1;
      p.write    = is_write;
      r          = rand_bits(2);
      p.datamode = datamode_t'(r[1:0]);
      r          = rand_bits(4);
      p.ctrlmode = r[3:0];
      r          = rand_bits(7);
      lo         = (r[2:0] >> p.datamode) << p.datamode;   // size aligned
      p.dstaddr  = {24'h800000, 1'b0, r[6:3], lo};        // 16 word window
      p.data     = rand_bits(32);
      p.srcaddr  = rand_bits(32);
      return p;
   endfunction

   task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
      checks++;
      assert (got === exp)
      else
      begin
         $display("Error: %0t %s got %h expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic check_true(input bit cond, input string what);
      checks++;
      assert (cond)
      else
      begin
         $display("Error: %0t %s", $time, what);
         errors++;
      end
   endtask

   task automatic report_test(input int num, input string name, input int mark);
      $display("test %0d %s done, %0d errors", num, name, errors - mark);
   endtask

   task automatic wait_idle();
      while (exp_aw.size() != 0 || exp_w.size() != 0 || exp_rsp.size() != 0 || rd_q.size() != 0)
         @(negedge m_axi_aclk);
      repeat (4) @(negedge m_axi_aclk);
   endtask

   // ##############################
   // stimulus
   // ##############################
   task automatic run_writes(input int n);
      int          sent;
      logic [31:0] r;
      axi_addr_t   a;
      sent = 0;
      while (sent < n)
      begin
         @(negedge m_axi_aclk);
         r = rand_bits(2);
         if (!rxwr_wait && r[1:0] != 2'b00)   // gap about one in four
         begin
            rxwr_packet = random_packet(1'b1);
            rxwr_access = 1'b1;
            a.addr      = rxwr_packet.dstaddr;
            a.size      = {1'b0, rxwr_packet.datamode};
            exp_aw.push_back(a);
            exp_w.push_back(expect_wbeat(rxwr_packet));
            sent++;
         end
         else
            rxwr_access = 1'b0;
      end
      @(negedge m_axi_aclk);
      rxwr_access = 1'b0;
      wait_idle();
   endtask

   task automatic run_reads(input int n);
      logic [31:0] r;
      for (int k = 0; k < n; k++)
      begin
         r = rand_bits(2);
         repeat (r[1:0])
         begin
            @(negedge m_axi_aclk);
            rxrd_access = 1'b0;
         end
         @(negedge m_axi_aclk);
         rd_pkt      = random_packet(1'b0);
         rxrd_packet = rd_pkt;
         rxrd_access = 1'b1;
         do
            @(posedge m_axi_aclk);
         while (rxrd_wait);   // held until the ar handshake
      end
      @(negedge m_axi_aclk);
      rxrd_access = 1'b0;
      wait_idle();
   endtask

   // ##############################
   // slave drive, falling edge
   // ##############################
   initial
   begin
      logic [31:0] r;
      logic        taken;
      m_axi_awready = 1'b0;
      m_axi_wready  = 1'b0;
      m_axi_arready = 1'b0;
      m_axi_rvalid  = 1'b0;
      m_axi_rdata   = '0;
      txrr_wait     = 1'b0;
      forever
      begin
         @(negedge m_axi_aclk);
         taken = m_axi_rvalid && m_axi_rready;   // handshake of the last rising edge
         if (rand_slave)
         begin
            r             = rand_bits(6);
            m_axi_awready = r[1] | r[0];         // high three times in four
            m_axi_wready  = r[3] | r[2];
            m_axi_arready = r[5] | r[4];
         end
         else
         begin
            m_axi_awready = 1'b1;
            m_axi_wready  = 1'b1;
            m_axi_arready = 1'b1;
         end
         if (!m_axi_rvalid || taken)             // rvalid held until taken
         begin
            r            = rand_slave ? rand_bits(1) : 32'd1;
            m_axi_rvalid = (rd_q.size() != 0) && r[0];
         end
         m_axi_rdata = (rd_q.size() != 0) ? rd_q[0] : '0;
         if (rand_wait)
         begin
            r         = rand_bits(2);
            txrr_wait = (r[1:0] == 2'b00);
         end
         else
            txrr_wait = 1'b0;
      end
   end

   // ##############################
   // monitor and model, rising edge
   // ##############################
   initial
   begin
      axi_addr_t  a;
      axi_wdata_t w;
      logic [63:0] word;
      forever
      begin
         @(posedge m_axi_aclk);
         cycle++;
         if (m_axi_aresetn)
         begin
            if (m_axi_awvalid && m_axi_awready)
            begin
               check_true(exp_aw.size() != 0, "aw beat with no write outstanding");
               if (exp_aw.size() != 0)
               begin
                  check_value("m_axi_awaddr", 64'(m_axi_awaddr), 64'(exp_aw[0].addr));
                  check_value("m_axi_awsize", 64'(m_axi_awsize), 64'(exp_aw[0].size));
                  void'(exp_aw.pop_front());
               end
               a.addr = m_axi_awaddr;
               a.size = m_axi_awsize;
               seen_aw.push_back(a);
            end
            if (m_axi_wvalid && m_axi_wready)
            begin
               check_true(exp_w.size() != 0, "w beat with no write outstanding");
               if (exp_w.size() != 0)
               begin
                  check_value("m_axi_wdata", m_axi_wdata, exp_w[0].data);
                  check_value("m_axi_wstrb", 64'(m_axi_wstrb), 64'(exp_w[0].strb));
                  check_value("m_axi_wlast", 64'(m_axi_wlast), 64'd1);
                  void'(exp_w.pop_front());
               end
               w.data = m_axi_wdata;
               w.strb = m_axi_wstrb;
               seen_w.push_back(w);
            end
            while (seen_aw.size() != 0 && seen_w.size() != 0)   // both halves seen
               merge_write(seen_aw.pop_front(), seen_w.pop_front());

            if (m_axi_arvalid && m_axi_arready)
            begin
               ar_count++;
               check_value("m_axi_araddr", 64'(m_axi_araddr), 64'(rd_pkt.dstaddr));
               check_value("m_axi_arsize", 64'(m_axi_arsize), 64'(rd_pkt.datamode));
               word = mem_word(m_axi_araddr[31:3]);
               rd_q.push_back(word);
               exp_rsp.push_back(expect_rsp(rd_pkt, word));
            end
            if (m_axi_rvalid && m_axi_rready)
            begin
               void'(rd_q.pop_front());
               r_cycle_q.push_back(cycle);
            end
            check_value("m_axi_rready", 64'(m_axi_rready), 64'(!txrr_wait));   // stalled by wait

            if (txrr_access)
            begin
               rsp_count++;
               check_true(exp_rsp.size() != 0, "response packet with no read outstanding");
               if (exp_rsp.size() != 0)
               begin
                  check_value("txrr_packet.access", 64'(txrr_packet.access),
                              64'(exp_rsp[0].access));
                  check_value("txrr_packet.write", 64'(txrr_packet.write), 64'(exp_rsp[0].write));
                  check_value("txrr_packet.datamode", 64'(txrr_packet.datamode),
                              64'(exp_rsp[0].datamode));
                  check_value("txrr_packet.ctrlmode", 64'(txrr_packet.ctrlmode),
                              64'(exp_rsp[0].ctrlmode));
                  check_value("txrr_packet.dstaddr", 64'(txrr_packet.dstaddr),
                              64'(exp_rsp[0].dstaddr));
                  check_value("txrr_packet.data", 64'(txrr_packet.data), 64'(exp_rsp[0].data));
                  check_value("txrr_packet.srcaddr", 64'(txrr_packet.srcaddr),
                              64'(exp_rsp[0].srcaddr));
                  void'(exp_rsp.pop_front());
               end
               if (r_cycle_q.size() != 0)
                  check_value("response latency", 64'(cycle - r_cycle_q.pop_front()), 64'd2);
            end
            if (txrr_wait)
            begin
               if (txrr_access)
                  wait_rsp++;
               check_true(wait_rsp <= 2, "more than two responses after txrr_wait rose");
            end
            else
               wait_rsp = 0;
         end
      end
   end

   // ##############################
   // test sequence
   // ##############################
   initial
   begin
      int mark;
      int ar_mark;
      int rsp_mark;
      m_axi_aresetn = 1'b0;
      rxwr_access   = 1'b0;
      rxwr_packet   = '0;
      rxrd_access   = 1'b0;
      rxrd_packet   = '0;
      rd_pkt        = '0;
      rand_slave    = 1'b0;
      rand_wait     = 1'b0;
      repeat (2) @(negedge m_axi_aclk);
      m_axi_aresetn = 1'b1;

      mark = errors;
      @(negedge m_axi_aclk);
      check_value("m_axi_awvalid", 64'(m_axi_awvalid), 64'd0);
      check_value("m_axi_wvalid", 64'(m_axi_wvalid), 64'd0);
      check_value("m_axi_arvalid", 64'(m_axi_arvalid), 64'd0);
      check_value("txrr_access", 64'(txrr_access), 64'd0);
      check_value("rxwr_wait", 64'(rxwr_wait), 64'd0);
      report_test(1, "reset state", mark);

      mark = errors;
      run_writes(n_wr_basic);
      report_test(2, "aligned writes", mark);

      mark       = errors;
      rand_slave = 1'b1;
      run_writes(n_wr_rand);
      rand_slave = 1'b0;
      report_test(3, "writes under random ready", mark);

      mark = errors;
      run_reads(n_rd_basic);
      report_test(4, "read responses", mark);

      mark       = errors;
      ar_mark    = ar_count;
      rsp_mark   = rsp_count;
      rand_slave = 1'b1;
      run_reads(n_rd_rand);
      check_value("ar handshakes", 64'(ar_count - ar_mark), 64'(n_rd_rand));
      check_value("response count", 64'(rsp_count - rsp_mark), 64'(ar_count - ar_mark));
      report_test(5, "reads under random arready", mark);

      mark      = errors;
      ar_mark   = ar_count;
      rsp_mark  = rsp_count;
      rand_wait = 1'b1;
      run_reads(n_rd_wait);
      rand_wait  = 1'b0;
      rand_slave = 1'b0;
      check_value("ar handshakes", 64'(ar_count - ar_mark), 64'(n_rd_wait));
      check_value("response count", 64'(rsp_count - rsp_mark), 64'(ar_count - ar_mark));
      report_test(6, "reads under random txrr_wait", mark);

      errors += dut.u_emaxi_checker.fail_count;   // bound protocol assertions
      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

   // watchdog, bound from the packet counts
   initial
   begin
      #(pkt_total * cycle_bound * 2 * clk_half);
      $display("Error: watchdog expired at %0t, the DUT stopped making progress", $time);
      $display("CHECKS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== bench/emaxi_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module emaxi_checker (
   input  logic                             m_axi_aclk,
   input  logic                             m_axi_aresetn,
   input  logic                             rxwr_access,
   input  logic                             rxwr_wait,
   input  logic [emaxi_pkg::addr_w-1:0]     m_axi_awaddr,
   input  logic                             m_axi_awvalid,
   input  logic                             m_axi_awready,
   input  logic [emaxi_pkg::axi_data_w-1:0] m_axi_wdata,
   input  logic                             m_axi_wvalid,
   input  logic                             m_axi_wready
);

   int fail_count;   // failed assertions so far

   // ##############################
   // stalled beats hold still
   // ##############################
   a_aw_hold: assert property (@(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
      m_axi_awvalid && !m_axi_awready |=> m_axi_awvalid && $stable(m_axi_awaddr))
      else
      begin
         fail_count++;
         $error("aw beat dropped or changed while stalled");
      end

   a_w_hold: assert property (@(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
      m_axi_wvalid && !m_axi_wready |=> m_axi_wvalid && $stable(m_axi_wdata))
      else
      begin
         fail_count++;
         $error("w beat dropped or changed while stalled");
      end

   // skid fills only from an accepted write
   a_wait_rise: assert property (@(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
      $rose(rxwr_wait) |-> $past(rxwr_access))
      else
      begin
         fail_count++;
         $error("rxwr_wait rose without a write accepted the cycle before");
      end

endmodule

bind emaxi_top emaxi_checker u_emaxi_checker (
   .m_axi_aclk    (m_axi_aclk),
   .m_axi_aresetn (m_axi_aresetn),
   .rxwr_access   (rxwr_access),
   .rxwr_wait     (rxwr_wait),
   .m_axi_awaddr  (m_axi_awaddr),
   .m_axi_awvalid (m_axi_awvalid),
   .m_axi_awready (m_axi_awready),
   .m_axi_wdata   (m_axi_wdata),
   .m_axi_wvalid  (m_axi_wvalid),
   .m_axi_wready  (m_axi_wready)
);

`default_nettype wire

// ==== hdl/emaxi_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module emaxi_top (
   input  logic                             m_axi_aclk,
   input  logic                             m_axi_aresetn,
   // elink side
   input  logic                             rxwr_access,
   input  emaxi_pkg::emesh_packet_t         rxwr_packet,
   output logic                             rxwr_wait,
   input  logic                             rxrd_access,
   input  emaxi_pkg::emesh_packet_t         rxrd_packet,
   output logic                             rxrd_wait,
   output logic                             txrr_access,
   output emaxi_pkg::emesh_packet_t         txrr_packet,
   input  logic                             txrr_wait,
   // axi write address
   output logic [emaxi_pkg::addr_w-1:0]     m_axi_awaddr,
   output logic [emaxi_pkg::axi_size_w-1:0] m_axi_awsize,
   output logic                             m_axi_awvalid,
   input  logic                             m_axi_awready,
   // axi write data
   output logic [emaxi_pkg::axi_data_w-1:0] m_axi_wdata,
   output logic [emaxi_pkg::axi_strb_w-1:0] m_axi_wstrb,
   output logic                             m_axi_wlast,
   output logic                             m_axi_wvalid,
   input  logic                             m_axi_wready,
   // axi read address
   output logic [emaxi_pkg::addr_w-1:0]     m_axi_araddr,
   output logic [emaxi_pkg::axi_size_w-1:0] m_axi_arsize,
   output logic                             m_axi_arvalid,
   input  logic                             m_axi_arready,
   // axi read data
   input  logic [emaxi_pkg::axi_data_w-1:0] m_axi_rdata,
   input  logic                             m_axi_rvalid,
   output logic                             m_axi_rready
);

   import emaxi_pkg::*;

   axi_addr_t  aw_beat;
   axi_wdata_t w_beat;
   axi_addr_t  ar_beat;

   write_port u_write_port (
      .m_axi_aclk    (m_axi_aclk),
      .m_axi_aresetn (m_axi_aresetn),
      .rxwr_access   (rxwr_access),
      .rxwr_packet   (rxwr_packet),
      .rxwr_wait     (rxwr_wait),
      .aw_valid      (m_axi_awvalid),
      .aw            (aw_beat),
      .aw_ready      (m_axi_awready),
      .w_valid       (m_axi_wvalid),
      .w             (w_beat),
      .w_ready       (m_axi_wready)
   );

   read_port u_read_port (
      .m_axi_aclk    (m_axi_aclk),
      .m_axi_aresetn (m_axi_aresetn),
      .rxrd_access   (rxrd_access),
      .rxrd_packet   (rxrd_packet),
      .rxrd_wait     (rxrd_wait),
      .ar_valid      (m_axi_arvalid),
      .ar            (ar_beat),
      .ar_ready      (m_axi_arready),
      .r_valid       (m_axi_rvalid),
      .r_data        (m_axi_rdata),
      .r_ready       (m_axi_rready),
      .txrr_access   (txrr_access),
      .txrr_packet   (txrr_packet),
      .txrr_wait     (txrr_wait)
   );

   // split beats onto the bus
   assign m_axi_awaddr = aw_beat.addr;
   assign m_axi_awsize = aw_beat.size;
   assign m_axi_wdata  = w_beat.data;
   assign m_axi_wstrb  = w_beat.strb;
   assign m_axi_wlast  = 1'b1;   // every write is one beat
   assign m_axi_araddr = ar_beat.addr;
   assign m_axi_arsize = ar_beat.size;

endmodule

`default_nettype wire

// ==== hdl/read_port.sv ====
`timescale 1ns/10ps
`default_nettype none

module read_port (
   input  logic                             m_axi_aclk,
   input  logic                             m_axi_aresetn,
   input  logic                             rxrd_access,
   input  emaxi_pkg::emesh_packet_t         rxrd_packet,
   output logic                             rxrd_wait,
   output logic                             ar_valid,
   output emaxi_pkg::axi_addr_t             ar,
   input  logic                             ar_ready,
   input  logic                             r_valid,
   input  logic [emaxi_pkg::axi_data_w-1:0] r_data,
   output logic                             r_ready,
   output logic                             txrr_access,
   output emaxi_pkg::emesh_packet_t         txrr_packet,
   input  logic                             txrr_wait
);

   import emaxi_pkg::*;

   readinfo_t         push_info;
   readinfo_t         head;
   logic              fifo_full;
   logic              ar_hs;
   logic              r_hs;
   logic [data_w-1:0] rsp_data;      // steered, right aligned
   emesh_packet_t     rsp_packet;
   logic              s1_valid;
   emesh_packet_t     s1_packet;

   // ##############################
   // read address issue
   // ##############################
   assign ar_valid  = rxrd_access & ~fifo_full;   // no issue without room for its info
   assign ar_hs     = ar_valid & ar_ready;
   assign rxrd_wait = ~ar_hs;                     // sender holds until taken
   assign ar        = '{addr: rxrd_packet.dstaddr, size: {1'b0, rxrd_packet.datamode}};

   // what the response will need
   assign push_info = '{srcaddr:  rxrd_packet.srcaddr,
                        addr_lo:  rxrd_packet.dstaddr[2:0],
                        ctrlmode: rxrd_packet.ctrlmode,
                        datamode: rxrd_packet.datamode};

   readinfo_fifo u_readinfo_fifo (
      .m_axi_aclk    (m_axi_aclk),
      .m_axi_aresetn (m_axi_aresetn),
      .push          (ar_hs),        // only on the handshake
      .push_info     (push_info),
      .pop           (r_hs),
      .head          (head),
      .full          (fifo_full)
   );

   // ##############################
   // response steering
   // ##############################
   assign r_ready = ~txrr_wait;
   assign r_hs    = r_valid & r_ready;

   // in-order returns, so head belongs to this beat
   always_comb
   begin
      rsp_data = '0;   // unfilled upper bits
      unique case (head.datamode)
         dm_byte: rsp_data[7:0]  = r_data[{head.addr_lo, 3'b000} +: 8];
         dm_half: rsp_data[15:0] = r_data[{head.addr_lo[2:1], 4'b0000} +: 16];
         dm_word: rsp_data       = r_data[{head.addr_lo[2], 5'b00000} +: 32];
         default: rsp_data       = r_data[data_w-1:0];   // dword low word
      endcase
   end

   always_comb
   begin
      rsp_packet          = '0;
      rsp_packet.access   = 1'b1;
      rsp_packet.write    = 1'b1;              // read response goes out as a write
      rsp_packet.datamode = head.datamode;
      rsp_packet.ctrlmode = head.ctrlmode;
      rsp_packet.dstaddr  = head.srcaddr;      // back to the requester
      rsp_packet.data     = rsp_data;
      rsp_packet.srcaddr  = r_data[axi_data_w-1 -: addr_w];   // upper word, always
   end

   // ##############################
   // two stage response pipeline
   // ##############################
   always_ff @(posedge m_axi_aclk)
   begin
      if (!m_axi_aresetn)
      begin
         s1_valid    <= 1'b0;
         txrr_access <= 1'b0;
      end
      else
      begin
         s1_valid    <= r_hs;
         txrr_access <= s1_valid;
      end
   end

   // packet follows its strobe through both stages
   always_ff @(posedge m_axi_aclk)
   begin
      if (r_hs)
         s1_packet <= rsp_packet;
      if (s1_valid)
         txrr_packet <= s1_packet;
   end

endmodule

`default_nettype wire

// ==== hdl/readinfo_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module readinfo_fifo (
   input  logic                 m_axi_aclk,
   input  logic                 m_axi_aresetn,
   input  logic                 push,
   input  emaxi_pkg::readinfo_t push_info,
   input  logic                 pop,
   output emaxi_pkg::readinfo_t head,
   output logic                 full
);

   import emaxi_pkg::*;

   readinfo_t                      mem [readinfo_depth];
   logic [readinfo_depth_log2-1:0] wr_ptr;   // wraps naturally, depth is a power of two
   logic [readinfo_depth_log2-1:0] rd_ptr;
   logic [readinfo_depth_log2:0]   count;
   logic                           do_push;
   logic                           do_pop;

   assign full    = count[readinfo_depth_log2];   // count == depth
   assign do_push = push & ~full;
   assign do_pop  = pop & (count != '0);
   assign head    = mem[rd_ptr];                  // oldest entry

   // pointers and fill level
   always_ff @(posedge m_axi_aclk)
   begin
      if (!m_axi_aresetn)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
         unique case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // both or neither
         endcase
      end
   end

   // storage
   always_ff @(posedge m_axi_aclk)
   begin
      if (do_push)
         mem[wr_ptr] <= push_info;
   end

endmodule

`default_nettype wire

// ==== hdl/write_port.sv ====
`timescale 1ns/10ps
`default_nettype none

module write_port (
   input  logic                     m_axi_aclk,
   input  logic                     m_axi_aresetn,
   input  logic                     rxwr_access,
   input  emaxi_pkg::emesh_packet_t rxwr_packet,
   output logic                     rxwr_wait,
   output logic                     aw_valid,
   output emaxi_pkg::axi_addr_t     aw,
   input  logic                     aw_ready,
   output logic                     w_valid,
   output emaxi_pkg::axi_wdata_t    w,
   input  logic                     w_ready
);

   import emaxi_pkg::*;

   axi_addr_t  aw_beat;
   axi_wdata_t w_beat;
   logic       aw_busy;
   logic       w_busy;

   // ##############################
   // address beat
   // ##############################
   always_comb
   begin
      aw_beat.addr = rxwr_packet.dstaddr;
      aw_beat.size = {1'b0, rxwr_packet.datamode};   // single beat, size = datamode
   end

   // ##############################
   // data and strobe alignment
   // ##############################
   // data replicated over all lanes, strobes pick the lane
   always_comb
   begin
      unique case (rxwr_packet.datamode)
         dm_byte:
         begin
            w_beat.data = {8{rxwr_packet.data[7:0]}};
            w_beat.strb = 8'h01 << rxwr_packet.dstaddr[2:0];
         end
         dm_half:
         begin
            w_beat.data = {4{rxwr_packet.data[15:0]}};
            w_beat.strb = 8'h03 << {rxwr_packet.dstaddr[2:1], 1'b0};
         end
         dm_word:
         begin
            w_beat.data = {2{rxwr_packet.data[31:0]}};
            w_beat.strb = 8'h0f << {rxwr_packet.dstaddr[2], 2'b00};
         end
         default:   // dword, srcaddr carries the upper half
         begin
            w_beat.data = {rxwr_packet.srcaddr, rxwr_packet.data};
            w_beat.strb = 8'hff;
         end
      endcase
   end

   // ##############################
   // channel stages
   // ##############################
   axi_skid_stage #(.payload_t(axi_addr_t)) u_aw_stage (
      .m_axi_aclk    (m_axi_aclk),
      .m_axi_aresetn (m_axi_aresetn),
      .load          (rxwr_access),
      .load_data     (aw_beat),
      .busy          (aw_busy),
      .out_valid     (aw_valid),
      .out_data      (aw),
      .out_ready     (aw_ready)
   );

   axi_skid_stage #(.payload_t(axi_wdata_t)) u_w_stage (
      .m_axi_aclk    (m_axi_aclk),
      .m_axi_aresetn (m_axi_aresetn),
      .load          (rxwr_access),
      .load_data     (w_beat),
      .busy          (w_busy),
      .out_valid     (w_valid),
      .out_data      (w),
      .out_ready     (w_ready)
   );

   assign rxwr_wait = aw_busy | w_busy;   // either channel backed up

endmodule

`default_nettype wire

// ==== hdl/axi_skid_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module axi_skid_stage #(
   parameter type payload_t = logic
) (
   input  logic     m_axi_aclk,
   input  logic     m_axi_aresetn,
   input  logic     load,        // new beat this cycle
   input  payload_t load_data,
   output logic     busy,        // skid entry occupied
   output logic     out_valid,
   output payload_t out_data,
   input  logic     out_ready
);

   logic     out_free;           // output reg empty or draining
   logic     skid_valid;
   payload_t skid_data;

   assign out_free = ~out_valid | out_ready;
   assign busy     = skid_valid;

   // ##############################
   // control
   // ##############################
   always_ff @(posedge m_axi_aclk)
   begin
      if (!m_axi_aresetn)
      begin
         out_valid  <= 1'b0;
         skid_valid <= 1'b0;
      end
      else if (out_free)
      begin
         out_valid  <= skid_valid | load;
         skid_valid <= skid_valid & load;   // skid moves up, new beat waits behind it
      end
      else if (load)
         skid_valid <= 1'b1;                // output stalled, park the beat
   end

   // ##############################
   // payload
   // ##############################
   always_ff @(posedge m_axi_aclk)
   begin
      if (out_free)
         out_data <= skid_valid ? skid_data : load_data;   // oldest beat first
      if (load && (skid_valid || !out_free))
         skid_data <= load_data;
   end

endmodule

`default_nettype wire

// ==== hdl/emaxi_pkg.sv ====
`default_nettype none

package emaxi_pkg;

   // ##############################
   // widths
   // ##############################
   localparam int addr_w              = 32;   // elink and axi address
   localparam int data_w              = 32;   // elink data
   localparam int axi_data_w          = 64;
   localparam int axi_strb_w          = axi_data_w / 8;
   localparam int axi_size_w          = 3;    // axsize field
   localparam int readinfo_depth_log2 = 5;
   localparam int readinfo_depth      = 1 << readinfo_depth_log2;

   // ##############################
   // elink packet
   // ##############################
   typedef enum logic [1:0] {
      dm_byte  = 2'd0,
      dm_half  = 2'd1,
      dm_word  = 2'd2,
      dm_dword = 2'd3
   } datamode_t;

   // 104 bits, access on top
   typedef struct packed {
      logic              access;
      logic              write;
      datamode_t         datamode;
      logic [3:0]        ctrlmode;
      logic [addr_w-1:0] dstaddr;
      logic [data_w-1:0] data;
      logic [addr_w-1:0] srcaddr;   // upper word of a dword write
   } emesh_packet_t;

   // ##############################
   // axi beats
   // ##############################
   typedef struct packed {
      logic [addr_w-1:0]     addr;
      logic [axi_size_w-1:0] size;  // log2 bytes, same code as datamode
   } axi_addr_t;

   typedef struct packed {
      logic [axi_data_w-1:0] data;
      logic [axi_strb_w-1:0] strb;
   } axi_wdata_t;

   // one outstanding read, what the response needs back
   typedef struct packed {
      logic [addr_w-1:0] srcaddr;   // becomes response dstaddr
      logic [2:0]        addr_lo;   // byte lane within the 64-bit word
      logic [3:0]        ctrlmode;
      datamode_t         datamode;
   } readinfo_t;

endpackage

`default_nettype wire
